// ==== source/rv32Pkg.sv ====
package rv32Pkg;

    // RV32I major opcodes, instruction[6:0]
    localparam logic [6:0] opLoad   = 7'b0000011;   // lb lh lw lbu lhu
    localparam logic [6:0] opStore  = 7'b0100011;   // sb sh sw
    localparam logic [6:0] opBranch = 7'b1100011;   // beq .. bgeu
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opImm    = 7'b0010011;   // register-immediate alu ops
    localparam logic [6:0] opReg    = 7'b0110011;   // register-register alu ops
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;

    // alu result select, independent of instruction format
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
        aluSrl, aluSra, aluOr, aluAnd, aluPassB
    } aluOpT;

    // what lands in rd
    typedef enum logic [1:0] {
        wbAlu,      // alu result
        wbMem,      // extended load data
        wbImm,      // immediate, used by lui
        wbLink      // pc + 4 for jal/jalr
    } wbSrcT;

    // branch conditions, funct3 of opBranch
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // access sizes, funct3 of opLoad / opStore
    localparam logic [2:0] f3Byte  = 3'b000;
    localparam logic [2:0] f3Half  = 3'b001;
    localparam logic [2:0] f3Word  = 3'b010;
    localparam logic [2:0] f3ByteU = 3'b100;   // loads only
    localparam logic [2:0] f3HalfU = 3'b101;   // loads only

endpackage

// ==== source/instrDecode.sv ====
`timescale 1ns/10ps

module instrDecode import rv32Pkg::*; (
    input  logic [31:0] instruction,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [4:0]  rd,
    output logic [2:0]  funct3,
    output aluOpT       aluOp,
    output logic        aluSrcImm,      // operand b from imm
    output logic        aluSrcPc,       // operand a from pc
    output wbSrcT       wbSrc,
    output logic        regWrite,
    output logic        isBranch,
    output logic        isJump,         // jal or jalr
    output logic        isJalr,
    output logic        memWrite,
    output logic        memRead,
    output logic        illegalInstr
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic       altOp;                   // funct7[5] selects sub / sra

    // field slicing, fixed positions in every format
    assign opcode = instruction[6:0];
    assign rd     = instruction[11:7];
    assign funct3 = instruction[14:12];
    assign rs1    = instruction[19:15];
    assign rs2    = instruction[24:20];
    assign funct7 = instruction[31:25];

    // op-imm has no subi, so alt only counts for srai there
    assign altOp = funct7[5] && (opcode == opReg || funct3 == 3'b101);

    function automatic aluOpT arithOp(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  arithOp = alt ? aluSub : aluAdd;
            3'b001:  arithOp = aluSll;
            3'b010:  arithOp = aluSlt;
            3'b011:  arithOp = aluSltu;
            3'b100:  arithOp = aluXor;
            3'b101:  arithOp = alt ? aluSra : aluSrl;
            3'b110:  arithOp = aluOr;
            default: arithOp = aluAnd;
        endcase
    endfunction

    always_comb begin
        aluOp        = aluAdd;           // address calc is the common case
        aluSrcImm    = 1'b0;
        aluSrcPc     = 1'b0;
        wbSrc        = wbAlu;
        regWrite     = 1'b0;
        isBranch     = 1'b0;
        isJump       = 1'b0;
        isJalr       = 1'b0;
        memWrite     = 1'b0;
        memRead      = 1'b0;
        illegalInstr = 1'b0;
        case (opcode)
            opReg: begin
                aluOp = arithOp(funct3, altOp);
                // only 0x00, or 0x20 on add/sra, is a legal funct7
                if (funct7 == 7'h00 || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    regWrite = 1'b1;
                end else begin
                    illegalInstr = 1'b1;
                end
            end
            opImm: begin
                aluOp     = arithOp(funct3, altOp);
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            opLui: begin
                aluOp     = aluPassB;        // aluResult shows the upper imm
                aluSrcImm = 1'b1;
                wbSrc     = wbImm;
                regWrite  = 1'b1;
            end
            opAuipc: begin
                aluSrcPc  = 1'b1;            // pc + imm
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            opJal: begin
                aluSrcPc  = 1'b1;            // target shows on aluResult
                aluSrcImm = 1'b1;
                wbSrc     = wbLink;
                regWrite  = 1'b1;
                isJump    = 1'b1;
            end
            opJalr: begin
                aluSrcImm = 1'b1;            // rs1 + imm, bit 0 cleared at top
                wbSrc     = wbLink;
                regWrite  = 1'b1;
                isJump    = 1'b1;
                isJalr    = 1'b1;
            end
            opBranch: begin
                aluOp    = aluSub;           // compare through the subtractor
                isBranch = 1'b1;
            end
            opLoad: begin
                aluSrcImm = 1'b1;
                wbSrc     = wbMem;
                regWrite  = 1'b1;
                memRead   = 1'b1;
            end
            opStore: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            default: illegalInstr = 1'b1;   // fence, system, anything else
        endcase
        assert (!(memRead && memWrite))
            else $error("decode: load and store active together");
    end

endmodule

// ==== source/immGen.sv ====
`timescale 1ns/10ps

module immGen import rv32Pkg::*; (
    input  logic [31:0] instruction,
    output logic [31:0] imm
);

    logic [6:0] opcode;
    logic       sign;                    // every format takes its sign from bit 31

    assign opcode = instruction[6:0];
    assign sign   = instruction[31];

    always_comb begin
        case (opcode)
            // I format
            opImm, opLoad, opJalr: begin
                imm = {{20{sign}}, instruction[31:20]};
            end
            // S format, split across rd slot
            opStore: begin
                imm = {{20{sign}}, instruction[31:25], instruction[11:7]};
            end
            // B format, bit 0 implied zero
            opBranch: begin
                imm = {{19{sign}}, instruction[31], instruction[7],
                       instruction[30:25], instruction[11:8], 1'b0};
            end
            // U format, low 12 bits zero
            opLui, opAuipc: begin
                imm = {instruction[31:12], 12'b0};
            end
            // J format
            opJal: begin
                imm = {{11{sign}}, instruction[31], instruction[19:12],
                       instruction[20], instruction[30:21], 1'b0};
            end
            default: imm = '0;              // R type and unknown
        endcase
    end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/10ps

module alu import rv32Pkg::*; (
    input  logic [31:0] operandA,
    input  logic [31:0] operandB,
    input  aluOpT       aluOp,
    input  logic [2:0]  funct3,          // branch condition when isBranch
    input  logic        isBranch,
    output logic [31:0] result,
    output logic        zero,
    output logic        condTrue
);

    logic [4:0]  shamt;
    logic [31:0] sum;
    logic [31:0] difference;
    logic        lessSigned;
    logic        lessUnsigned;

    assign shamt        = operandB[4:0];  // upper bits ignored, imm or reg
    assign sum          = operandA + operandB;
    assign difference   = operandA - operandB;
    assign lessSigned   = $signed(operandA) < $signed(operandB);
    assign lessUnsigned = operandA < operandB;

    always_comb begin
        case (aluOp)
            aluAdd:   result = sum;
            aluSub:   result = difference;
            aluSll:   result = operandA << shamt;
            aluSlt:   result = {31'b0, lessSigned};
            aluSltu:  result = {31'b0, lessUnsigned};
            aluXor:   result = operandA ^ operandB;
            aluSrl:   result = operandA >> shamt;
            aluSra:   result = $signed(operandA) >>> shamt;
            aluOr:    result = operandA | operandB;
            aluAnd:   result = operandA & operandB;
            aluPassB: result = operandB;     // lui
            default:  result = '0;           // unused encodings
        endcase
    end

    assign zero = (result == '0);

    // branches run aluSub, so zero means equal
    always_comb begin
        condTrue = 1'b0;
        if (isBranch) begin
            case (funct3)
                f3Beq:   condTrue = zero;
                f3Bne:   condTrue = !zero;
                f3Blt:   condTrue = lessSigned;
                f3Bge:   condTrue = !lessSigned;
                f3Bltu:  condTrue = lessUnsigned;
                f3Bgeu:  condTrue = !lessUnsigned;
                default: condTrue = 1'b0;    // 010 / 011 reserved
            endcase
        end
    end

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/10ps

module registerFile #(
    parameter int regCount = 32          // 16 for rv32e
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        writeEnable,
    input  logic [4:0]  readAddrA,
    input  logic [4:0]  readAddrB,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData,
    output logic [31:0] readDataA,
    output logic [31:0] readDataB
);

    logic [31:0] regs [regCount];

    // x0 and anything past the implemented set read zero
    function automatic logic [31:0] readPort(input logic [4:0] addr);
        if (addr == '0 || int'(addr) >= regCount) begin
            readPort = '0;
        end else begin
            readPort = regs[addr];
        end
    endfunction

    assign readDataA = readPort(readAddrA);   // async read
    assign readDataB = readPort(readAddrB);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0 && int'(writeAddr) < regCount) begin
            regs[writeAddr] <= writeData;
        end
    end

    // x0 storage stays clear across every write after reset
    regZeroClear: assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
        else $error("register file: x0 storage changed");

endmodule

// ==== source/memoryHandler.sv ====
`timescale 1ns/10ps

module memoryHandler import rv32Pkg::*; (
    input  logic [31:0] addr,            // byte address from alu
    input  logic [31:0] storeData,       // rs2 value
    input  logic [31:0] memReadData,     // whole word from memory
    input  logic [2:0]  funct3,          // access size
    input  logic        memRead,
    input  logic        memWrite,
    output logic [31:0] memAddr,
    output logic [31:0] memWriteData,
    output logic [3:0]  memByteEnable,
    output logic [31:0] loadData,
    output logic        misaligned
);

    logic [1:0]  offset;
    logic [31:0] readShifted;
    logic [15:0] readHalf;
    logic [3:0]  laneMask;

    assign offset      = addr[1:0];
    assign memAddr     = {addr[31:2], 2'b00};            // word aligned
    assign readShifted = memReadData >> {offset, 3'b000}; // byte lane to bits 7:0
    assign readHalf    = offset[1] ? memReadData[31:16] : memReadData[15:0];

    // store side, lane shift plus enables
    always_comb begin
        case (funct3)
            f3Byte: begin
                memWriteData = {24'b0, storeData[7:0]} << {offset, 3'b000};
                laneMask     = 4'b0001 << offset;
            end
            f3Half: begin
                memWriteData = {16'b0, storeData[15:0]} << {offset[1], 4'b0000};
                laneMask     = 4'b0011 << {offset[1], 1'b0};
            end
            f3Word: begin
                memWriteData = storeData;
                laneMask     = 4'b1111;
            end
            default: begin
                memWriteData = storeData;
                laneMask     = 4'b0000;      // no such store size
            end
        endcase
        memByteEnable = memWrite ? laneMask : 4'b0000;
        assert (memWrite || memByteEnable == 4'b0000)
            else $error("memory handler: byte enables without a store");
    end

    // load side, lane select then extend
    always_comb begin
        case (funct3)
            f3Byte:  loadData = {{24{readShifted[7]}}, readShifted[7:0]};
            f3ByteU: loadData = {24'b0, readShifted[7:0]};
            f3Half:  loadData = {{16{readHalf[15]}}, readHalf};
            f3HalfU: loadData = {16'b0, readHalf};
            f3Word:  loadData = memReadData;
            default: loadData = '0;
        endcase
    end

    // flag only, access still goes out
    always_comb begin
        case (funct3)
            f3Half, f3HalfU: misaligned = (memRead || memWrite) && offset[0];
            f3Word:          misaligned = (memRead || memWrite) && (offset != 2'b00);
            default:         misaligned = 1'b0;
        endcase
    end

endmodule

// ==== source/datapathTop.sv ====
`timescale 1ns/10ps

module datapathTop import rv32Pkg::*; #(
    parameter int regCount = 32
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instruction,
    input  logic [31:0] pc,
    input  logic [31:0] memReadData,
    output logic [31:0] aluResult,
    output logic [31:0] nextPc,
    output logic        branchTaken,
    output logic [31:0] memAddr,
    output logic [31:0] memWriteData,
    output logic [3:0]  memByteEnable,
    output logic        memWrite,
    output logic        memRead,
    output logic        illegalInstr,
    output logic        misaligned
);

    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    aluOpT       aluOp;
    wbSrcT       wbSrc;
    logic        aluSrcImm;
    logic        aluSrcPc;
    logic        regWrite;
    logic        isBranch;
    logic        isJump;
    logic        isJalr;
    logic        condTrue;
    logic [31:0] imm;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] operandA;
    logic [31:0] operandB;
    logic [31:0] loadData;
    logic [31:0] writeBackData;
    logic [31:0] pcPlus4;
    logic [31:0] pcTarget;

    instrDecode decoder (
        .instruction(instruction), .rs1(rs1), .rs2(rs2), .rd(rd), .funct3(funct3),
        .aluOp(aluOp), .aluSrcImm(aluSrcImm), .aluSrcPc(aluSrcPc), .wbSrc(wbSrc),
        .regWrite(regWrite), .isBranch(isBranch), .isJump(isJump), .isJalr(isJalr),
        .memWrite(memWrite), .memRead(memRead), .illegalInstr(illegalInstr)
    );

    immGen makeImm (
        .instruction(instruction), .imm(imm)
    );

    registerFile #(.regCount(regCount)) regs (
        .clk(clk), .reset(reset),
        .writeEnable(regWrite && !illegalInstr),   // no write on an illegal op
        .readAddrA(rs1), .readAddrB(rs2), .writeAddr(rd), .writeData(writeBackData),
        .readDataA(rs1Data), .readDataB(rs2Data)
    );

    // operand muxes
    assign operandA = aluSrcPc ? pc : rs1Data;    // auipc, jal
    assign operandB = aluSrcImm ? imm : rs2Data;

    alu aluUnit (
        .operandA(operandA), .operandB(operandB), .aluOp(aluOp), .funct3(funct3),
        .isBranch(isBranch), .result(aluResult),
        .zero(),                                   // read by the branch logic inside the alu
        .condTrue(condTrue)
    );

    memoryHandler mem (
        .addr(aluResult), .storeData(rs2Data), .memReadData(memReadData),
        .funct3(funct3), .memRead(memRead), .memWrite(memWrite),
        .memAddr(memAddr), .memWriteData(memWriteData), .memByteEnable(memByteEnable),
        .loadData(loadData), .misaligned(misaligned)
    );

    // write-back mux
    always_comb begin
        case (wbSrc)
            wbAlu:   writeBackData = aluResult;
            wbMem:   writeBackData = loadData;
            wbImm:   writeBackData = imm;
            default: writeBackData = pcPlus4;    // wbLink
        endcase
    end

    // next pc
    assign pcPlus4     = pc + 32'd4;
    assign pcTarget    = pc + imm;               // jal and branch target
    assign branchTaken = isJump || (isBranch && condTrue);

    always_comb begin
        if (isJalr) begin
            nextPc = {aluResult[31:1], 1'b0};   // rs1 + imm with lsb dropped
        end else if (branchTaken) begin
            nextPc = pcTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

endmodule

// ==== dv/datapathTasks.svh ====
// reference model state
logic [31:0] refRegs [32];
logic [31:0] refMem [256];
logic [31:0] expAlu;
logic [31:0] expNext;
logic [31:0] expWb;
logic [31:0] expWdata;
logic [3:0]  expBe;
logic        expAluValid;
logic        expWr;
logic        expTaken;
logic        expIllegal;
logic        expMis;
logic        expStore;
logic        expLoad;

function automatic logic [31:0] fillWord(input int idx);
    fillWord = {idx[7:0], ~idx[7:0], idx[7:0] ^ 8'h5a, idx[7:0] + 8'h33};
endfunction

// instruction encoders
function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    rType = {f7, rs2, rs1, f3, rd, opReg};
endfunction

function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    iType = {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    sType = {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
endfunction

function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    bType = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
endfunction

function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
    uType = {imm, rd, op};
endfunction

function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
    jType = {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
endfunction

// rv32i integer ops by funct3
function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                      input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0: arith = alt ? a - b : a + b;
        3'd1: arith = a << b[4:0];
        3'd2: arith = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: arith = (a < b) ? 32'd1 : 32'd0;
        3'd4: arith = a ^ b;
        3'd5: begin
            if (alt) begin
                arith = $signed(a) >>> b[4:0];   // sign fill
            end else begin
                arith = a >> b[4:0];
            end
        end
        3'd6: arith = a | b;
        default: arith = a & b;
    endcase
endfunction

// expected response of one instruction from the current model state
task automatic predict(input logic [31:0] ins, input logic [31:0] pcv);
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immJ;
    logic [31:0] lane;
    f3   = ins[14:12];
    a    = refRegs[ins[19:15]];
    b    = refRegs[ins[24:20]];
    immI = {{20{ins[31]}}, ins[31:20]};
    immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    expAlu      = 32'h0;
    expAluValid = 1'b0;
    expWr       = 1'b0;
    expWb       = 32'h0;
    expTaken    = 1'b0;
    expNext     = pcv + 32'd4;
    expIllegal  = 1'b0;
    expMis      = 1'b0;
    expStore    = 1'b0;
    expLoad     = 1'b0;
    expBe       = 4'b0000;
    expWdata    = 32'h0;
    case (ins[6:0])
        opReg: begin
            if (ins[31:25] == 7'h00 || (ins[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                expAlu      = arith(f3, ins[30], a, b);
                expAluValid = 1'b1;
                expWr       = 1'b1;
                expWb       = expAlu;
            end else begin
                expIllegal = 1'b1;           // undefined funct7
            end
        end
        opImm: begin
            expAlu      = arith(f3, f3 == 3'd5 && ins[30], a, immI);   // srai only
            expAluValid = 1'b1;
            expWr       = 1'b1;
            expWb       = expAlu;
        end
        opLui: begin
            expAlu      = {ins[31:12], 12'b0};
            expAluValid = 1'b1;
            expWr       = 1'b1;
            expWb       = expAlu;
        end
        opAuipc: begin
            expAlu      = pcv + {ins[31:12], 12'b0};
            expAluValid = 1'b1;
            expWr       = 1'b1;
            expWb       = expAlu;
        end
        opJal: begin
            expWr    = 1'b1;
            expWb    = pcv + 32'd4;          // link
            expTaken = 1'b1;
            expNext  = pcv + immJ;
        end
        opJalr: begin
            expWr    = 1'b1;
            expWb    = pcv + 32'd4;
            expTaken = 1'b1;
            expNext  = (a + immI) & ~32'd1;
        end
        opBranch: begin
            case (f3)
                3'd0: expTaken = (a == b);
                3'd1: expTaken = (a != b);
                3'd4: expTaken = ($signed(a) < $signed(b));
                3'd5: expTaken = ($signed(a) >= $signed(b));
                3'd6: expTaken = (a < b);
                default: expTaken = (a >= b);
            endcase
            if (expTaken) begin
                expNext = pcv + immB;
            end
        end
        opLoad: begin
            expAlu      = a + immI;          // byte address
            expAluValid = 1'b1;
            expLoad     = 1'b1;
            expWr       = 1'b1;
            lane        = refMem[expAlu[9:2]] >> {expAlu[1:0], 3'b000};
            case (f3)
                3'd0: expWb = {{24{lane[7]}}, lane[7:0]};
                3'd4: expWb = {24'b0, lane[7:0]};
                3'd1: expWb = {{16{lane[15]}}, lane[15:0]};
                3'd5: expWb = {16'b0, lane[15:0]};
                default: expWb = lane;
            endcase
        end
        opStore: begin
            expAlu      = a + immS;
            expAluValid = 1'b1;
            expStore    = 1'b1;
            case (f3)
                3'd0: begin
                    expBe    = 4'b0001 << expAlu[1:0];
                    expWdata = {24'b0, b[7:0]} << {expAlu[1:0], 3'b000};
                end
                3'd1: begin
                    expBe    = 4'b0011 << expAlu[1:0];
                    expWdata = {16'b0, b[15:0]} << {expAlu[1:0], 3'b000};
                end
                default: begin
                    expBe    = 4'b1111;
                    expWdata = b;
                end
            endcase
        end
        default: expIllegal = 1'b1;          // fence, system, custom
    endcase
    if (expLoad || expStore) begin
        expMis = (f3[1:0] == 2'd1 && expAlu[0]) || (f3 == 3'd2 && expAlu[1:0] != 2'd0);
    end
endtask

// drive and check one instruction before its write edge
task automatic issue(input logic [31:0] ins, input logic [31:0] pcv);
    predict(ins, pcv);
    @(posedge clk);
    #1;
    instruction = ins;
    pc          = pcv;
    #6;                                      // 1 ns before the write edge
    checkValue("nextPc", nextPc, expNext);
    checkValue("branchTaken", 32'(branchTaken), 32'(expTaken));
    checkValue("illegalInstr", 32'(illegalInstr), 32'(expIllegal));
    checkValue("memWrite", 32'(memWrite), 32'(expStore));
    checkValue("memRead", 32'(memRead), 32'(expLoad));
    checkValue("misaligned", 32'(misaligned), 32'(expMis));
    if (expAluValid) begin
        checkValue("aluResult", aluResult, expAlu);
    end
    if (expLoad || expStore) begin
        checkValue("memAddr", memAddr, {expAlu[31:2], 2'b00});   // word aligned
    end
    if (!expStore) begin
        checkValue("memByteEnable", 32'(memByteEnable), 32'h0);
    end else if (!expMis) begin
        checkValue("memByteEnable", 32'(memByteEnable), 32'(expBe));
        checkValue("memWriteData", memWriteData, expWdata);
        for (int i = 0; i < 4; i++) begin
            if (expBe[i]) begin
                refMem[expAlu[9:2]][8*i +: 8] = expWdata[8*i +: 8];
            end
        end
    end
    if (expWr && !expIllegal && ins[11:7] != 5'd0) begin
        refRegs[ins[11:7]] = expWb;
    end
endtask

task automatic setReg(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;                 // addi sign-extends its low 12 bits
    issue(uType(upper[31:12], rd, opLui), 32'h0);
    issue(iType(value[11:0], rd, 3'b000, rd, opImm), 32'h0);
endtask

// sw to a scratch word puts the register on memWriteData
task automatic observeReg(input logic [4:0] rs);
    issue(sType(12'h200, rs, 5'd0, f3Word), 32'h0);
endtask

task automatic applyReset();
    @(posedge clk);                          // last pending write lands
    #1;
    reset       = 1'b1;
    instruction = 32'h0000_0013;             // addi x0,x0,0
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < 32; i++) begin
        refRegs[i] = 32'h0;
    end
endtask

task automatic resetReadsZero();
    for (int r = 1; r < 32; r++) begin
        issue(iType(12'(r * 37 + 1), 5'd0, 3'b000, 5'(r), opImm), 32'h0);   // nonzero first
    end
    applyReset();
    for (int r = 1; r < 32; r++) begin
        issue(sType(12'(r * 4), 5'(r), 5'd0, f3Word), 32'h0);
        checkValue("memWriteData after reset", memWriteData, 32'h0);
    end
endtask

task automatic aluOps();
    logic [4:0]  rd;
    logic [11:0] imm;
    for (int round = 0; round < 4; round++) begin
        setReg(5'd1, $urandom());
        setReg(5'd2, $urandom());
        for (int k = 0; k < 8; k++) begin
            rd = 5'($urandom_range(31, 0));  // x0 now and then
            issue(rType(7'h00, 5'd2, 5'd1, 3'(k), rd), 32'h0);
            observeReg(rd);
            if (k == 0 || k == 5) begin
                issue(rType(7'h20, 5'd2, 5'd1, 3'(k), rd), 32'h0);   // sub, sra
                observeReg(rd);
            end
            imm = (k == 1 || k == 5) ? {7'h00, 5'($urandom())} : 12'($urandom());
            issue(iType(imm, 5'd1, 3'(k), rd, opImm), 32'h0);
            if (k == 5) begin
                issue(iType({7'h20, imm[4:0]}, 5'd1, 3'(k), rd, opImm), 32'h0);   // srai
            end
            observeReg(rd);
        end
    end
    issue(iType(12'h123, 5'd1, 3'b000, 5'd0, opImm), 32'h0);
    observeReg(5'd0);
    checkValue("x0 after write", memWriteData, 32'h0);
endtask

task automatic storeLanes();
    setReg(5'd5, 32'h100);                   // base
    setReg(5'd6, $urandom());
    for (int off = 0; off < 4; off++) begin
        issue(sType(12'(off), 5'd6, 5'd5, f3Byte), 32'h0);
        if (off == 0 || off == 2) begin
            issue(sType(12'(off), 5'd6, 5'd5, f3Half), 32'h0);
        end
    end
    issue(sType(12'h000, 5'd6, 5'd5, f3Word), 32'h0);
    // flagged accesses go to a word that is never loaded
    issue(sType(12'h201, 5'd6, 5'd5, f3Half), 32'h0);
    issue(sType(12'h203, 5'd6, 5'd5, f3Half), 32'h0);
    for (int off = 1; off < 4; off++) begin
        issue(sType(12'(12'h200 + off), 5'd6, 5'd5, f3Word), 32'h0);
    end
endtask

task automatic loadAndConfirm(input logic [2:0] f3, input logic [11:0] imm);
    issue(iType(imm, 5'd5, f3, 5'd7, opLoad), 32'h0);
    issue(sType(12'h084, 5'd7, 5'd0, f3Word), 32'h0);
endtask

task automatic loadExtend();
    setReg(5'd5, 32'h180);
    for (int w = 0; w < 4; w++) begin
        setReg(5'd6, w[0] ? ($urandom() | 32'h8000_8080) : $urandom());   // negative lanes
        issue(sType(12'(w * 4), 5'd6, 5'd5, f3Word), 32'h0);
    end
    for (int w = 0; w < 4; w++) begin
        for (int off = 0; off < 4; off++) begin
            loadAndConfirm(f3Byte, 12'(w * 4 + off));
            loadAndConfirm(f3ByteU, 12'(w * 4 + off));
            if (off == 0 || off == 2) begin
                loadAndConfirm(f3Half, 12'(w * 4 + off));
                loadAndConfirm(f3HalfU, 12'(w * 4 + off));
            end
        end
        loadAndConfirm(f3Word, 12'(w * 4));
    end
endtask

task automatic controlFlow();
    logic [31:0] pcv;
    for (int round = 0; round < 8; round++) begin
        setReg(5'd8, $urandom());
        if (round[0]) begin
            setReg(5'd9, refRegs[8]);        // equal operands
        end else begin
            setReg(5'd9, $urandom());
        end
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) begin
                continue;                    // reserved conditions
            end
            pcv = $urandom() & 32'hffff_fffc;
            issue(bType(13'($urandom()), 5'd9, 5'd8, 3'(f)), pcv);
        end
    end
    for (int round = 0; round < 6; round++) begin
        pcv = $urandom() & 32'hffff_fffc;
        issue(jType(21'($urandom()), 5'd10), pcv);
        observeReg(5'd10);
        setReg(5'd11, $urandom());
        issue(iType(12'($urandom()), 5'd11, 3'b000, 5'd12, opJalr), pcv);
        observeReg(5'd12);
        issue(uType(20'($urandom()), 5'd13, opAuipc), pcv);
        observeReg(5'd13);
    end
endtask

task automatic illegalOps();
    setReg(5'd14, $urandom());
    issue({17'($urandom()), 3'b000, 5'd14, 7'b0001011}, 32'h0);   // custom opcode
    issue({17'($urandom()), 3'b000, 5'd14, 7'b1110011}, 32'h0);   // system
    issue(rType(7'h7f, 5'd1, 5'd2, 3'b000, 5'd14), 32'h0);
    observeReg(5'd14);
endtask

// ==== dv/datapathTb.sv ====
`timescale 1ns/10ps

module datapathTb import rv32Pkg::*; ();

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic [31:0] memReadData;
    logic [31:0] aluResult;
    logic [31:0] nextPc;
    logic        branchTaken;
    logic [31:0] memAddr;
    logic [31:0] memWriteData;
    logic [3:0]  memByteEnable;
    logic        memWrite;
    logic        memRead;
    logic        illegalInstr;
    logic        misaligned;

    logic [31:0] mem [256];                  // 1 KiB data memory, word indexed

    datapathTop #(.regCount(32)) uut (
        .clk(clk), .reset(reset), .instruction(instruction), .pc(pc),
        .memReadData(memReadData), .aluResult(aluResult), .nextPc(nextPc),
        .branchTaken(branchTaken), .memAddr(memAddr), .memWriteData(memWriteData),
        .memByteEnable(memByteEnable), .memWrite(memWrite), .memRead(memRead),
        .illegalInstr(illegalInstr), .misaligned(misaligned)
    );

    assign memReadData = mem[memAddr[9:2]];  // async read, upper bits wrap

    // byte lane writes land at the same edge as the register write
    always @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (memByteEnable[i]) begin
                mem[memAddr[9:2]][8*i +: 8] <= memWriteData[8*i +: 8];
            end
        end
    end

    `include "datapathTasks.svh"

    task automatic failRun(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] want);
        assert (got === want)
            else failRun($sformatf("%s is %h, expected %h", what, got, want));
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;               // 8 ns period
    end

    // bounds the whole run
    initial begin
        repeat (5000) @(posedge clk);
        $display("Timeout: the test sequence did not finish within 5000 clock cycles");
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(32'h08e9cabd));      // single seed for the run
        reset       = 1'b1;
        instruction = 32'h0000_0013;         // addi x0,x0,0
        pc          = 32'h0;
        for (int i = 0; i < 256; i++) begin
            mem[i]    = fillWord(i);
            refMem[i] = fillWord(i);
        end
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = 32'h0;
        end
        repeat (2) @(posedge clk);           // two reset edges
        #1;
        reset = 1'b0;
        resetReadsZero();
        aluOps();
        storeLanes();
        loadExtend();
        controlFlow();
        illegalOps();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+dv
source/rv32Pkg.sv
source/instrDecode.sv
source/immGen.sv
source/alu.sv
source/registerFile.sv
source/memoryHandler.sv
source/datapathTop.sv
dv/datapathTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = datapathTb
FILELIST  = src.f
BUILD     = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
